// File: sim.f
+incdir+include
logic/uart_pkg.sv
logic/uart_link_if.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_ctrl.sv
logic/uart_top.sv
dv/uart_checker.sv
dv/tb_uart.sv

// File: Makefile
TOP := tb_uart

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: dv/tb_uart.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_uart import uart_pkg::*; ();

    logic       clk_bus;
    logic       clk_uart;
    logic       rst_n;
    logic       wr_en;
    logic [7:0] wr_data;
    logic       tx_full;
    logic       tx_empty;
    logic       rd_en;
    logic [7:0] rd_data;
    logic       rd_frame_err;
    logic       rx_empty;
    logic       rx_overrun;
    logic       txd;
    logic       rxd;
    logic       loop_sel;  // High while the testbench drives rxd
    logic       tb_rxd;
    int         seed;
    int         tb_errors;

    assign rxd = loop_sel ? tb_rxd : txd;

    always #20 clk_bus = !clk_bus;
    always #10 clk_uart = !clk_uart;

    uart_top uart_top_i (
        .clk_bus(clk_bus), .clk_uart(clk_uart), .rst_n(rst_n),
        .wr_en(wr_en), .wr_data(wr_data), .tx_full(tx_full), .tx_empty(tx_empty),
        .rd_en(rd_en), .rd_data(rd_data), .rd_frame_err(rd_frame_err),
        .rx_empty(rx_empty), .rx_overrun(rx_overrun), .txd(txd), .rxd(rxd)
    );

    uart_checker checker_i (
        .clk_bus(clk_bus), .clk_uart(clk_uart), .rst_n(rst_n),
        .wr_en(wr_en), .wr_data(wr_data), .tx_full(tx_full), .txd(txd),
        .rd_en(rd_en), .rd_data(rd_data), .rd_frame_err(rd_frame_err),
        .rx_empty(rx_empty), .rx_overrun(rx_overrun)
    );

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h expected %h", name, got, exp);
            tb_errors++;
        end
    endtask

    // Waits on the falling edge until the named level matches, within limit bus cycles
    task automatic wait_level(input string name, input logic exp, input int limit);
        int   n;
        logic v;
        n = 0;
        forever begin
            case (name)
                "tx_full":    v = tx_full;
                "tx_empty":   v = tx_empty;
                "rx_empty":   v = rx_empty;
                default:      v = rx_overrun;
            endcase
            if (v === exp || n >= limit) begin
                break;
            end
            @(negedge clk_bus);
            n++;
        end
        if (v !== exp) begin
            $display("Timed out after %0d bus cycles waiting for %s to be %0d", n, name, exp);
            tb_errors++;
        end
    endtask

    task automatic write_byte(input uart_byte_t b);
        wait_level("tx_full", 1'b0, 400);
        wr_en   = 1'b1;
        wr_data = b;
        @(negedge clk_bus);
        wr_en = 1'b0;
    endtask

    task automatic read_frame();
        wait_level("rx_empty", 1'b0, 600);
        rd_en = 1'b1;
        @(negedge clk_bus);
        rd_en = 1'b0;
    endtask

    function automatic uart_byte_t next_random();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Serial frame on rxd, one bit every four bus cycles
    task automatic drive_line_frame(input uart_byte_t b, input logic stop);
        logic [`UART_FRAME_BITS-1:0] bits;
        bits = {stop, b, 1'b0};
        for (int i = 0; i < `UART_FRAME_BITS; i++) begin
            tb_rxd = bits[i];
            repeat (`UART_BIT_CYCLES / 2) @(negedge clk_bus);
        end
        tb_rxd = 1'b1;
    endtask

    initial begin
        uart_byte_t b;
        clk_bus   = 1'b0;
        clk_uart  = 1'b0;
        rst_n     = 1'b0;
        wr_en     = 1'b0;
        wr_data   = '0;
        rd_en     = 1'b0;
        loop_sel  = 1'b0;
        tb_rxd    = 1'b1;
        seed      = 32'h3d10;
        tb_errors = 0;
        repeat (3) @(posedge clk_bus);
        @(negedge clk_bus);
        rst_n = 1'b1;
        @(negedge clk_bus);

        check_level("txd", txd, 1'b1);
        check_level("tx_empty", tx_empty, 1'b1);
        check_level("rx_empty", rx_empty, 1'b1);
        check_level("tx_full", tx_full, 1'b0);
        check_level("rx_overrun", rx_overrun, 1'b0);

        write_byte(8'ha5);  // Single loopback
        read_frame();
        wait_level("tx_empty", 1'b1, 200);

        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    write_byte(next_random());
                end
            end
            begin
                for (int i = 0; i < 12; i++) begin
                    read_frame();
                end
            end
        join
        wait_level("tx_empty", 1'b1, 200);

        fork
            begin
                for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
                    write_byte(next_random());
                end
                check_level("tx_full", tx_full, 1'b1);
                wr_en   = 1'b1;  // Dropped while the queue is full
                wr_data = 8'h3c;
                @(negedge clk_bus);
                wr_en = 1'b0;
            end
            begin
                for (int i = 0; i < `UART_FIFO_DEPTH + 1; i++) begin
                    read_frame();
                end
            end
        join
        wait_level("tx_empty", 1'b1, 200);

        b        = next_random();
        loop_sel = 1'b1;
        checker_i.expect_read(b, 1'b1);
        drive_line_frame(b, 1'b0);
        read_frame();
        loop_sel = 1'b0;

        for (int i = 0; i < `UART_FIFO_DEPTH + 2; i++) begin
            write_byte(next_random());
        end
        wait_level("rx_overrun", 1'b1, 800);
        wait_level("tx_empty", 1'b1, 800);
        repeat (8) @(negedge clk_bus);  // Last frame reaches the bus side
        for (int i = 0; i < `UART_FIFO_DEPTH; i++) begin
            read_frame();
        end
        checker_i.clear_reads();
        check_level("rx_empty", rx_empty, 1'b1);
        check_level("rx_overrun", rx_overrun, 1'b1);

        if (checker_i.pending_lines() != 0) begin
            $display("%0d accepted bytes never appeared on txd", checker_i.pending_lines());
            tb_errors++;
        end
        $display("Errors: testbench %0d, checker %0d (frames %0d, reads %0d)",
                 tb_errors, checker_i.errors, checker_i.frames_seen, checker_i.reads_seen);
        if (tb_errors == 0 && checker_i.errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/uart_checker.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_checker import uart_pkg::*; (
    input  logic       clk_bus,
    input  logic       clk_uart,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       tx_full,
    input  logic       txd,
    input  logic       rd_en,
    input  logic [7:0] rd_data,
    input  logic       rd_frame_err,
    input  logic       rx_empty,
    input  logic       rx_overrun
);

    uart_byte_t     line_q[$];  // Accepted writes still to appear on txd
    uart_rx_frame_t read_q[$];  // Frames still to be read back
    int             errors;
    int             frames_seen;
    int             reads_seen;
    logic           overrun_seen;

    // Line order of a frame, bit 0 goes out first
    function automatic logic [`UART_FRAME_BITS-1:0] frame_bits(input uart_byte_t b);
        return {1'b1, b, 1'b0};
    endfunction

    function automatic int pending_lines();
        return line_q.size();
    endfunction

    task automatic expect_read(input uart_byte_t b, input logic err);
        uart_rx_frame_t f;
        f.data      = b;
        f.frame_err = err;
        read_q.push_back(f);
    endtask

    task automatic clear_reads();
        read_q.delete();  // Frames lost to overrun
    endtask

    initial begin
        errors      = 0;
        frames_seen = 0;
        reads_seen  = 0;
    end

    always @(posedge clk_bus) begin
        if (rst_n && wr_en && !tx_full) begin
            line_q.push_back(wr_data);
            expect_read(wr_data, 1'b0);  // txd loops back to rxd
        end
    end

    // Samples every clk_uart cycle of a frame on the falling edge
    initial begin
        logic                        prev;
        logic                        hold_bad;
        logic [`UART_FRAME_BITS-1:0] got;
        logic [`UART_FRAME_BITS-1:0] exp;
        prev = 1'b1;
        forever begin
            @(negedge clk_uart);
            if (rst_n && prev && !txd) begin
                got      = '0;
                hold_bad = 1'b0;
                if (line_q.size() == 0) begin
                    $display("Frame on txd without an accepted write");
                    errors++;
                    exp = '1;
                end else begin
                    exp = frame_bits(line_q.pop_front());
                end
                for (int i = 0; i < `UART_FRAME_BITS; i++) begin
                    for (int j = 0; j < `UART_BIT_CYCLES; j++) begin
                        if (i != 0 || j != 0) begin
                            @(negedge clk_uart);
                        end
                        if (j == `UART_BIT_CYCLES / 2) begin
                            got[i] = txd;
                        end
                        if (txd != exp[i]) begin
                            hold_bad = 1'b1;
                        end
                    end
                end
                if (got != exp) begin
                    $display("** Error txd frame: got %03h expected %03h", got, exp);
                    errors++;
                end else if (hold_bad) begin
                    $display("** Error txd bit timing: frame %03h not held %0d cycles per bit",
                             exp, `UART_BIT_CYCLES);
                    errors++;
                end
                frames_seen++;
            end
            prev = txd;
        end
    end

    always @(posedge clk_bus) begin
        uart_rx_frame_t e;
        if (rst_n && rd_en && !rx_empty) begin
            reads_seen++;
            if (read_q.size() == 0) begin
                $display("Read of a frame that was never expected");
                errors++;
            end else begin
                e = read_q.pop_front();
                if (rd_data != e.data) begin
                    $display("** Error rd_data: got %02h expected %02h", rd_data, e.data);
                    errors++;
                end
                if (rd_frame_err != e.frame_err) begin
                    $display("** Error rd_frame_err: got %h expected %h",
                             rd_frame_err, e.frame_err);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            overrun_seen <= 1'b0;
        end else begin
            if (overrun_seen && !rx_overrun) begin
                $display("** Error rx_overrun: got %h expected %h", rx_overrun, 1'b1);
                errors++;
            end
            overrun_seen <= overrun_seen | rx_overrun;  // Sticky until reset
        end
    end

endmodule

// File: logic/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
    input  logic       clk_bus,
    input  logic       clk_uart,
    input  logic       rst_n,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    output logic       tx_full,
    output logic       tx_empty,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       rd_frame_err,
    output logic       rx_empty,
    output logic       rx_overrun,
    output logic       txd,
    input  logic       rxd
);

    uart_link_if link ();

    logic           txq_pop;
    uart_byte_t     txq_head;
    logic           txq_empty;
    logic           rxq_push;
    logic           rxq_full;
    uart_rx_frame_t rxq_in;
    uart_rx_frame_t rxq_head;

    assign tx_empty     = txq_empty && link.tx_idle;
    assign rd_data      = rxq_head.data;
    assign rd_frame_err = rxq_head.frame_err;

    byte_fifo #(.payload_t(uart_byte_t)) tx_fifo_i (
        .clk_bus   (clk_bus),
        .rst_n     (rst_n),
        .push      (wr_en),
        .push_data (wr_data),
        .pop       (txq_pop),
        .pop_data  (txq_head),
        .full      (tx_full),
        .empty     (txq_empty)
    );

    byte_fifo #(.payload_t(uart_rx_frame_t)) rx_fifo_i (
        .clk_bus   (clk_bus),
        .rst_n     (rst_n),
        .push      (rxq_push),
        .push_data (rxq_in),
        .pop       (rd_en),
        .pop_data  (rxq_head),
        .full      (rxq_full),
        .empty     (rx_empty)
    );

    uart_ctrl uart_ctrl_i (
        .clk_bus    (clk_bus),
        .rst_n      (rst_n),
        .link       (link.ctrl),
        .txq_pop    (txq_pop),
        .txq_data   (txq_head),
        .txq_empty  (txq_empty),
        .rxq_push   (rxq_push),
        .rxq_data   (rxq_in),
        .rxq_full   (rxq_full),
        .rx_overrun (rx_overrun)
    );

    uart_tx uart_tx_i (
        .clk_bus  (clk_bus),
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .link     (link.tx),
        .txd      (txd)
    );

    uart_rx uart_rx_i (
        .clk_bus  (clk_bus),
        .clk_uart (clk_uart),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .link     (link.rx)
    );

endmodule

// File: logic/uart_ctrl.sv
`timescale 1ns/1ps

module uart_ctrl import uart_pkg::*; (
    input  logic           clk_bus,
    input  logic           rst_n,
    uart_link_if.ctrl      link,
    output logic           txq_pop,
    input  uart_byte_t     txq_data,
    input  logic           txq_empty,
    output logic           rxq_push,
    output uart_rx_frame_t rxq_data,
    input  logic           rxq_full,
    output logic           rx_overrun
);

    typedef enum logic {
        ISS_WAITING,
        ISS_ISSUED
    } issue_state_t;

    issue_state_t state;

    // WAITING only issues once tx_idle is back, so each request follows a full idle cycle
    assign txq_pop = (state == ISS_WAITING) && link.tx_idle && !txq_empty;

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            state           <= ISS_WAITING;
            link.tx_request <= 1'b0;
        end else begin
            link.tx_request <= txq_pop;
            case (state)
                ISS_WAITING: begin
                    if (txq_pop) begin
                        state <= ISS_ISSUED;
                    end
                end
                ISS_ISSUED: begin
                    if (!link.tx_idle) begin
                        state <= ISS_WAITING;  // Transmitter took the byte
                    end
                end
                default: state <= ISS_WAITING;
            endcase
        end
    end

    always_ff @(posedge clk_bus) begin
        if (txq_pop) begin
            link.tx_data <= txq_data;
        end
    end

    assign rxq_push = link.rx_valid && !rxq_full;
    assign rxq_data = link.rx_frame;

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            rx_overrun <= 1'b0;
        end else if (link.rx_valid && rxq_full) begin
            rx_overrun <= 1'b1;  // Sticky until reset
        end
    end

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_rx import uart_pkg::*; (
    input  logic           clk_bus,
    input  logic           clk_uart,
    input  logic           rst_n,
    input  logic           rxd,
    uart_link_if.rx        link
);

    localparam int unsigned BCW = $clog2(`UART_BIT_CYCLES);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    logic           rxd_meta;
    logic           rxd_s;
    logic           rxd_prev;
    rx_state_t      state;
    logic [BCW-1:0] baud_cnt;
    logic [2:0]     bit_idx;
    uart_byte_t     shift_data;
    uart_rx_frame_t frame_hold;
    logic           rx_toggle;

    logic           tog_s1;
    logic           tog_s2;
    logic           tog_s3;
    logic           frame_new;

    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta  <= 1'b1;
            rxd_s     <= 1'b1;
            rxd_prev  <= 1'b1;
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            rx_toggle <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_prev <= rxd_s;
            if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end
            case (state)
                RX_IDLE: begin
                    if (rxd_prev && !rxd_s) begin
                        baud_cnt <= BCW'(`UART_BIT_CYCLES / 2 - 1);  // Aim at the start bit centre
                        state    <= RX_START;
                    end
                end
                RX_START: begin
                    if (baud_cnt == '0) begin
                        if (rxd_s == START_BIT) begin
                            baud_cnt <= BCW'(`UART_BIT_CYCLES - 1);
                            bit_idx  <= '0;
                            state    <= RX_DATA;
                        end else begin
                            state <= RX_IDLE;  // Too short for a start bit
                        end
                    end
                end
                RX_DATA: begin
                    if (baud_cnt == '0) begin
                        baud_cnt <= BCW'(`UART_BIT_CYCLES - 1);
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (baud_cnt == '0) begin
                        rx_toggle <= !rx_toggle;  // frame_hold is loaded on this same edge
                        state     <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_uart) begin
        if (state == RX_DATA && baud_cnt == '0) begin
            shift_data <= {rxd_s, shift_data[7:1]};
        end
        if (state == RX_STOP && baud_cnt == '0) begin
            frame_hold.data      <= shift_data;
            frame_hold.frame_err <= (rxd_s != STOP_BIT);
        end
    end

    // The held frame is stable for a whole frame time after the toggle flips
    assign frame_new = tog_s2 ^ tog_s3;

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            tog_s1        <= 1'b0;
            tog_s2        <= 1'b0;
            tog_s3        <= 1'b0;
            link.rx_valid <= 1'b0;
        end else begin
            tog_s1        <= rx_toggle;
            tog_s2        <= tog_s1;
            tog_s3        <= tog_s2;
            link.rx_valid <= frame_new;
        end
    end

    always_ff @(posedge clk_bus) begin
        if (frame_new) begin
            link.rx_frame <= frame_hold;
        end
    end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx import uart_pkg::*; (
    input  logic           clk_bus,
    input  logic           clk_uart,
    input  logic           rst_n,
    uart_link_if.tx        link,
    output logic           txd
);

    localparam int unsigned BCW = $clog2(`UART_BIT_CYCLES);
    localparam int unsigned FCW = $clog2(`UART_FRAME_BITS);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

    logic [`UART_REQ_STRETCH-1:0]  req_stage;
    logic                          req_hold;
    uart_byte_t                    data_reg;
    logic                          done_meta;
    logic                          done_sync;
    logic                          done_prev;

    logic                          req_meta;
    logic                          req_sync;
    logic                          req_prev;
    tx_state_t                     state;
    logic [`UART_FRAME_BITS-1:0]   send_buf;
    logic [FCW-1:0]                bits_left;
    logic [BCW-1:0]                baud_cnt;
    logic [`UART_DONE_STRETCH-1:0] done_sr;
    logic                          done_hold;

    // Bus side: latch the byte and stretch the request
    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            link.tx_idle <= 1'b1;
            req_stage    <= '0;
            req_hold     <= 1'b0;
            done_meta    <= 1'b0;
            done_sync    <= 1'b0;
            done_prev    <= 1'b0;
        end else begin
            done_meta <= done_hold;
            done_sync <= done_meta;
            done_prev <= done_sync;
            req_hold  <= |req_stage;  // Registered so the crossing sees a clean level
            req_stage <= req_stage << 1;
            if (link.tx_idle && link.tx_request) begin
                req_stage    <= `UART_REQ_STRETCH'(1);
                link.tx_idle <= 1'b0;
            end else if (done_prev && !done_sync) begin
                link.tx_idle <= 1'b1;  // Falling edge of the synchronized done
            end
        end
    end

    always_ff @(posedge clk_bus) begin
        if (link.tx_idle && link.tx_request) begin
            data_reg <= link.tx_data;
        end
    end

    // Uart side: frame the byte and shift it out LSB first
    always_ff @(posedge clk_uart or negedge rst_n) begin
        if (!rst_n) begin
            req_meta  <= 1'b0;
            req_sync  <= 1'b0;
            req_prev  <= 1'b0;
            state     <= TX_IDLE;
            txd       <= 1'b1;
            bits_left <= '0;
            baud_cnt  <= '0;
            done_sr   <= '0;
            done_hold <= 1'b0;
        end else begin
            req_meta  <= req_hold;
            req_sync  <= req_meta;
            req_prev  <= req_sync;
            done_hold <= |done_sr;
            done_sr   <= done_sr << 1;
            case (state)
                TX_IDLE: begin
                    if (req_sync && !req_prev) begin
                        txd       <= send_buf[0];  // data_reg has been stable since the request
                        bits_left <= FCW'(`UART_FRAME_BITS - 1);
                        baud_cnt  <= BCW'(`UART_BIT_CYCLES - 1);
                        state     <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (baud_cnt != '0) begin
                        baud_cnt <= baud_cnt - 1'b1;
                    end else if (bits_left != '0) begin
                        txd       <= send_buf[1];
                        bits_left <= bits_left - 1'b1;
                        baud_cnt  <= BCW'(`UART_BIT_CYCLES - 1);
                    end else begin
                        txd     <= STOP_BIT;
                        done_sr <= `UART_DONE_STRETCH'(1);
                        state   <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_uart) begin
        if (state == TX_IDLE) begin
            send_buf <= {STOP_BIT, data_reg, START_BIT};
        end else if (baud_cnt == '0) begin
            send_buf <= {1'b1, send_buf[`UART_FRAME_BITS-1:1]};
        end
    end

endmodule

// File: logic/byte_fifo.sv
`timescale 1ns/1ps
`include "uart_consts.svh"

module byte_fifo import uart_pkg::*; #(
    parameter type payload_t = uart_byte_t
) (
    input  logic     clk_bus,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int unsigned DEPTH = `UART_FIFO_DEPTH;
    localparam int unsigned PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CW    = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;   // A push on a full queue is lost
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];     // Head is visible without a pop

    always_ff @(posedge clk_bus) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_bus or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: logic/uart_link_if.sv
`timescale 1ns/1ps

interface uart_link_if import uart_pkg::*; ();

    logic           tx_request;  // One-cycle strobe on clk_bus
    uart_byte_t     tx_data;     // Valid with tx_request
    logic           tx_idle;     // Transmitter can take a byte
    logic           rx_valid;    // One-cycle strobe on clk_bus
    uart_rx_frame_t rx_frame;    // Valid with rx_valid

    modport ctrl (
        output tx_request,
        output tx_data,
        input  tx_idle,
        input  rx_valid,
        input  rx_frame
    );

    modport tx (
        input  tx_request,
        input  tx_data,
        output tx_idle
    );

    modport rx (
        output rx_valid,
        output rx_frame
    );

endinterface

// File: logic/uart_pkg.sv
package uart_pkg;

    // One data byte as it moves through the queues and the engines
    typedef logic [7:0] uart_byte_t;

    // A received frame as handed from the receiver to the bus side
    typedef struct packed {
        logic       frame_err;  // Stop bit was sampled as 0
        uart_byte_t data;       // Data bits, LSB received first
    } uart_rx_frame_t;

    // Line levels of the framing bits
    localparam logic START_BIT = 1'b0;
    localparam logic STOP_BIT  = 1'b1;

endpackage

// File: include/uart_consts.svh
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// clk_uart cycles per serial bit, kept small for simulation
`define UART_BIT_CYCLES 8

// Start bit, 8 data bits, stop bit
`define UART_FRAME_BITS 10

`define UART_FIFO_DEPTH 4

// Bus cycles the transmit request stays visible to the uart side
`define UART_REQ_STRETCH 7

// Uart cycles the done pulse stays visible to the bus side
`define UART_DONE_STRETCH 4

`endif
